// ==== logic/exec_defines.svh ====
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// datapath width
`define EXEC_XLEN 32

// register file geometry
`define EXEC_NREGS    8
`define EXEC_REG_BITS 3

// immediate field and the half-word loaded by ldi / ldh
`define EXEC_IMM_BITS 16

`endif

// ==== logic/exec_pkg.sv ====
`include "exec_defines.svh"

`default_nettype none

package exec_pkg;

  typedef enum logic [3:0] {
    OP_LDI, OP_LDH, OP_ADD, OP_ADC, OP_SUB, OP_SBB,
    OP_AND, OP_OR, OP_XOR, OP_MUL, OP_DIV, OP_CMP
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_MUL, ALU_DIV, ALU_LDH
  } alu_op_t;

  // 4 + 3*3 + 16 = 29 bits
  typedef struct packed {
    opcode_t                   opcode;
    logic [`EXEC_REG_BITS-1:0] rd;
    logic [`EXEC_REG_BITS-1:0] rs0;
    logic [`EXEC_REG_BITS-1:0] rs1;
    logic [`EXEC_IMM_BITS-1:0] imm;
  } insn_t;

  typedef struct packed {
    logic cf;
    logic pf;
    logic zf;
    logic sf;
    logic of;
  } status_t;

  typedef struct packed {
    alu_op_t op;
    logic    use_carry;  // adc / sbb
    logic    reg_wr;
    logic    flags_wr;
  } alu_cntl_t;

  typedef struct packed {
    logic                      valid;
    alu_cntl_t                 cntl;
    logic [`EXEC_REG_BITS-1:0] rd;
    logic [`EXEC_REG_BITS-1:0] rs0;
    logic [`EXEC_REG_BITS-1:0] rs1;
    logic [`EXEC_IMM_BITS-1:0] imm;
    logic                      use_imm;  // ldi only
  } decoded_t;

  typedef struct packed {
    logic                      valid;
    alu_cntl_t                 cntl;
    logic [`EXEC_REG_BITS-1:0] rd;
    logic [`EXEC_XLEN-1:0]     opnd0;
    logic [`EXEC_XLEN-1:0]     opnd1;
  } operands_t;

  // bypass out of execute and the registered writeback share this shape
  typedef struct packed {
    logic                      valid;
    logic [`EXEC_REG_BITS-1:0] rd;
    logic [`EXEC_XLEN-1:0]     value;
    logic                      reg_wr;
  } wb_t;

endpackage

`default_nettype wire

// ==== logic/insn_decode.sv ====
`default_nettype none

module insn_decode (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               insn_valid,
  input  exec_pkg::insn_t    insn,
  output exec_pkg::decoded_t decoded
);
  import exec_pkg::*;

  alu_cntl_t cntl;

  always_comb begin
    cntl.op        = ALU_ADD;
    cntl.use_carry = 1'b0;
    cntl.reg_wr    = (insn.opcode != OP_CMP);  // cmp only touches flags
    cntl.flags_wr  = !(insn.opcode inside {OP_LDI, OP_LDH});
    case (insn.opcode)
      OP_LDI: cntl.op = ALU_OR;  // 0 | imm
      OP_LDH: cntl.op = ALU_LDH;
      OP_ADD: cntl.op = ALU_ADD;
      OP_ADC: begin
        cntl.op        = ALU_ADD;
        cntl.use_carry = 1'b1;
      end
      OP_SUB: cntl.op = ALU_SUB;
      OP_SBB: begin
        cntl.op        = ALU_SUB;
        cntl.use_carry = 1'b1;
      end
      OP_AND: cntl.op = ALU_AND;
      OP_OR:  cntl.op = ALU_OR;
      OP_XOR: cntl.op = ALU_XOR;
      OP_MUL: cntl.op = ALU_MUL;
      OP_DIV: cntl.op = ALU_DIV;
      OP_CMP: cntl.op = ALU_SUB;
      // unused encodings fall through as a plain add
      default: cntl.op = ALU_ADD;
    endcase
  end

  always_ff @(posedge clk) begin
    decoded.cntl    <= cntl;
    decoded.rd      <= insn.rd;
    decoded.rs0     <= insn.rs0;
    decoded.rs1     <= insn.rs1;
    decoded.imm     <= insn.imm;
    decoded.use_imm <= (insn.opcode == OP_LDI);
    if (!rst_n) begin
      decoded.valid <= 1'b0;
    end else begin
      decoded.valid <= insn_valid;
    end
  end

endmodule

`default_nettype wire

// ==== logic/operand_fetch.sv ====
`include "exec_defines.svh"

`default_nettype none

module operand_fetch (
  input  logic                clk,
  input  logic                rst_n,
  input  exec_pkg::decoded_t  decoded,
  input  exec_pkg::wb_t       bypass,
  input  exec_pkg::wb_t       writeback,
  output exec_pkg::operands_t operands
);
  import exec_pkg::*;

  localparam int ZPAD = `EXEC_XLEN - `EXEC_IMM_BITS;

  logic [`EXEC_XLEN-1:0] regs [`EXEC_NREGS];
  logic [`EXEC_XLEN-1:0] src0;
  logic [`EXEC_XLEN-1:0] src1;
  logic [`EXEC_XLEN-1:0] opnd0;
  logic [`EXEC_XLEN-1:0] opnd1;

  // execute has priority over writeback and writeback over the file
  function automatic logic [`EXEC_XLEN-1:0] pick(
    input logic [`EXEC_REG_BITS-1:0] idx,
    input logic [`EXEC_XLEN-1:0]     rf_val,
    input wb_t                       byp,
    input wb_t                       wb
  );
    logic [`EXEC_XLEN-1:0] val;
    val = rf_val;
    if (wb.valid && wb.reg_wr && wb.rd == idx)
      val = wb.value;
    if (byp.valid && byp.reg_wr && byp.rd == idx)
      val = byp.value;
    return val;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `EXEC_NREGS; i++)
        regs[i] <= '0;
    end else if (writeback.valid && writeback.reg_wr) begin
      regs[writeback.rd] <= writeback.value;
    end
  end

  assign src0 = pick(decoded.rs0, regs[decoded.rs0], bypass, writeback);
  assign src1 = pick(decoded.rs1, regs[decoded.rs1], bypass, writeback);

  always_comb begin
    opnd0 = decoded.use_imm ? '0 : src0;
    if (decoded.use_imm)
      opnd1 = {{ZPAD{1'b0}}, decoded.imm};  // ldi
    else if (decoded.cntl.op == ALU_LDH)
      opnd1 = {decoded.imm, {ZPAD{1'b0}}};  // imm into the upper half
    else
      opnd1 = src1;
  end

  always_ff @(posedge clk) begin
    operands.cntl  <= decoded.cntl;
    operands.rd    <= decoded.rd;
    operands.opnd0 <= opnd0;
    operands.opnd1 <= opnd1;
    if (!rst_n)
      operands.valid <= 1'b0;
    else
      operands.valid <= decoded.valid;
  end

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`include "exec_defines.svh"

`default_nettype none

module alu (
  input  exec_pkg::alu_cntl_t   cntl,
  input  exec_pkg::status_t     status_in,
  input  logic [`EXEC_XLEN-1:0] opnd0,
  input  logic [`EXEC_XLEN-1:0] opnd1,
  output logic [`EXEC_XLEN-1:0] result,
  output exec_pkg::status_t     status_out
);
  import exec_pkg::*;

  localparam int W = `EXEC_XLEN;
  localparam int H = `EXEC_IMM_BITS;

  logic           carry_in;
  logic [W:0]     sum;
  logic [W:0]     diff;
  logic [2*W-1:0] product;
  logic           div_zero;
  logic [W-1:0]   quotient;
  status_t        flags_new;

  assign carry_in = cntl.use_carry & status_in.cf;

  // bit W is the carry out, or the borrow for diff
  assign sum      = {1'b0, opnd0} + {1'b0, opnd1} + {{W{1'b0}}, carry_in};
  assign diff     = {1'b0, opnd0} - {1'b0, opnd1} - {{W{1'b0}}, carry_in};
  assign product  = {{W{1'b0}}, opnd0} * {{W{1'b0}}, opnd1};
  assign div_zero = (opnd1 == '0);
  assign quotient = div_zero ? '1 : opnd0 / opnd1;

  always_comb begin
    flags_new    = status_in;
    flags_new.cf = 1'b0;  // logical ops leave cf/of clear
    flags_new.of = 1'b0;
    result       = '0;
    case (cntl.op)
      ALU_ADD: begin
        result       = sum[W-1:0];
        flags_new.cf = sum[W];
        flags_new.of = (opnd0[W-1] == opnd1[W-1]) && (sum[W-1] != opnd0[W-1]);
      end
      ALU_SUB: begin
        result       = diff[W-1:0];
        flags_new.cf = diff[W];
        flags_new.of = (opnd0[W-1] != opnd1[W-1]) && (diff[W-1] != opnd0[W-1]);
      end
      ALU_AND: result = opnd0 & opnd1;
      ALU_OR:  result = opnd0 | opnd1;
      ALU_XOR: result = opnd0 ^ opnd1;
      ALU_MUL: begin
        result       = product[W-1:0];
        flags_new.cf = |product[2*W-1:W];  // upper half lost
        flags_new.of = |product[2*W-1:W];
      end
      ALU_DIV: begin
        result       = quotient;
        flags_new.of = div_zero;
      end
      ALU_LDH: result = {opnd1[W-1:W-H], opnd0[W-H-1:0]};
      default: result = '0;
    endcase
    flags_new.pf = ~^result[7:0];  // even parity of the low byte
    flags_new.zf = (result == '0);
    flags_new.sf = result[W-1];
    status_out   = cntl.flags_wr ? flags_new : status_in;
  end

endmodule

`default_nettype wire

// ==== logic/execute_stage.sv ====
`include "exec_defines.svh"

`default_nettype none

module execute_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  exec_pkg::operands_t operands,
  output exec_pkg::wb_t       bypass,
  output exec_pkg::wb_t       writeback,
  output exec_pkg::status_t   status
);
  import exec_pkg::*;

  logic [`EXEC_XLEN-1:0] alu_result;
  status_t               alu_status;
  status_t               flags;

  alu alu0 (
    .cntl       (operands.cntl),
    .status_in  (flags),
    .opnd0      (operands.opnd0),
    .opnd1      (operands.opnd1),
    .result     (alu_result),
    .status_out (alu_status)
  );

  // the instruction in execute as seen by operand fetch this cycle
  assign bypass.valid  = operands.valid;
  assign bypass.rd     = operands.rd;
  assign bypass.value  = alu_result;
  assign bypass.reg_wr = operands.cntl.reg_wr;

  always_ff @(posedge clk) begin
    if (operands.valid) begin
      writeback.rd     <= operands.rd;
      writeback.value  <= alu_result;
      writeback.reg_wr <= operands.cntl.reg_wr;
    end
    if (!rst_n) begin
      writeback.valid <= 1'b0;
      flags           <= '0;
    end else begin
      writeback.valid <= operands.valid;
      if (operands.valid)
        flags <= alu_status;  // alu holds flags when flags_wr is clear
    end
  end

  assign status = flags;

endmodule

`default_nettype wire

// ==== logic/exec_core.sv ====
`include "exec_defines.svh"

`default_nettype none

module exec_core (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      insn_valid,
  input  exec_pkg::insn_t           insn,
  output logic                      result_valid,
  output logic [`EXEC_XLEN-1:0]     result,
  output logic [`EXEC_REG_BITS-1:0] result_rd,
  output exec_pkg::status_t         status
);
  import exec_pkg::*;

  decoded_t  decoded;
  operands_t operands;
  wb_t       bypass;
  wb_t       writeback;

  insn_decode decode0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .insn_valid (insn_valid),
    .insn       (insn),
    .decoded    (decoded)
  );

  operand_fetch fetch0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .decoded   (decoded),
    .bypass    (bypass),
    .writeback (writeback),
    .operands  (operands)
  );

  execute_stage exec0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .operands  (operands),
    .bypass    (bypass),
    .writeback (writeback),
    .status    (status)
  );

  // cmp reports its difference here but never lands in the file
  assign result_valid = writeback.valid;
  assign result       = writeback.value;
  assign result_rd    = writeback.rd;

endmodule

`default_nettype wire

// ==== testbench/exec_core_chk.sv ====
`default_nettype none

module exec_core_chk (
  input logic              clk,
  input logic              rst_n,
  input logic              insn_valid,
  input exec_pkg::insn_t   insn,
  input logic              result_valid,
  input exec_pkg::status_t status
);
  import exec_pkg::*;

  logic [2:0] ld_pipe;  // ldi/ldh issued one, two, three cycles back

  always_ff @(posedge clk) begin
    if (!rst_n)
      ld_pipe <= '0;
    else
      ld_pipe <= {ld_pipe[1:0], insn_valid && (insn.opcode inside {OP_LDI, OP_LDH})};
  end

  quiet_after_reset: assert property (@(posedge clk)
    !rst_n |=> !result_valid ##1 !result_valid)
    else $error("result_valid set during reset or the cycle after");

  three_cycle_latency: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid == $past(insn_valid, 3))
    else $error("result_valid does not follow insn_valid by three cycles");

  flags_hold_on_load: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid && ld_pipe[2] |-> $stable(status))
    else $error("status changed on a load result");

endmodule

`default_nettype wire

// ==== testbench/exec_core_tb.sv ====
`include "exec_defines.svh"

`default_nettype none

module exec_core_tb;
  import exec_pkg::*;

  typedef struct packed {
    logic [`EXEC_XLEN-1:0]     value;
    logic [`EXEC_REG_BITS-1:0] rd;
    status_t                   st;
  } expect_t;

  logic                      clk;
  logic                      rst_n;
  logic                      insn_valid;
  insn_t                     insn;
  logic                      result_valid;
  logic [`EXEC_XLEN-1:0]     result;
  logic [`EXEC_REG_BITS-1:0] result_rd;
  status_t                   status;

  logic [`EXEC_XLEN-1:0] model_regs [`EXEC_NREGS];
  status_t               model_flags;
  expect_t               exp_q [$];
  expect_t               head;
  logic [31:0]           rng;
  string                 test_name;
  int                    checks;
  int                    errors;
  int                    test_errors;
  int                    issued;
  int                    cycles;

  exec_core dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .insn_valid   (insn_valid),
    .insn         (insn),
    .result_valid (result_valid),
    .result       (result),
    .result_rd    (result_rd),
    .status       (status)
  );

  bind exec_core exec_core_chk chk0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .insn_valid   (insn_valid),
    .insn         (insn),
    .result_valid (result_valid),
    .status       (status)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] rand32();
    rng ^= rng << 13;
    rng ^= rng >> 17;
    rng ^= rng << 5;
    return rng;
  endfunction

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL %s expected %h actual %h", what, exp, act);
    end
  endtask

  // reference model that runs in program order at issue time
  task automatic model(input insn_t i);
    logic [`EXEC_XLEN-1:0] a;
    logic [`EXEC_XLEN-1:0] b;
    logic [`EXEC_XLEN-1:0] r;
    logic [63:0]           wide;
    longint                exact;
    longint                ci;
    status_t               f;
    a = model_regs[i.rs0];
    b = model_regs[i.rs1];
    ci = 0;
    if (i.opcode inside {OP_ADC, OP_SBB})
      ci = longint'(model_flags.cf);
    f = model_flags;
    f.cf = 1'b0;
    f.of = 1'b0;
    r = '0;
    case (i.opcode)
      OP_LDI: r = {16'h0, i.imm};
      OP_LDH: r = {i.imm, a[15:0]};
      OP_ADD, OP_ADC: begin
        wide  = 64'(a) + 64'(b) + 64'(ci);
        exact = longint'($signed(a)) + longint'($signed(b)) + ci;
        r     = wide[31:0];
        f.cf  = |wide[63:32];
        f.of  = exact != longint'($signed(r));  // exact sum does not fit
      end
      OP_SUB, OP_SBB, OP_CMP: begin
        wide  = 64'(a) - 64'(b) - 64'(ci);
        exact = longint'($signed(a)) - longint'($signed(b)) - ci;
        r     = wide[31:0];
        f.cf  = 64'(a) < 64'(b) + 64'(ci);  // borrow
        f.of  = exact != longint'($signed(r));
      end
      OP_AND: r = a & b;
      OP_OR:  r = a | b;
      OP_XOR: r = a ^ b;
      OP_MUL: begin
        wide = 64'(a) * 64'(b);
        r    = wide[31:0];
        f.cf = |wide[63:32];
        f.of = f.cf;
      end
      OP_DIV: begin
        r    = (b == 0) ? 32'hffff_ffff : a / b;
        f.of = (b == 0);
      end
      default: r = '0;
    endcase
    f.pf = ($countones(r[7:0]) % 2) == 0;
    f.zf = (r == 0);
    f.sf = r[31];
    if (!(i.opcode inside {OP_LDI, OP_LDH}))
      model_flags = f;
    if (i.opcode != OP_CMP)
      model_regs[i.rd] = r;
    exp_q.push_back('{r, i.rd, model_flags});
  endtask

  task automatic issue(input opcode_t op, input logic [2:0] rd, input logic [2:0] rs0,
                       input logic [2:0] rs1, input logic [15:0] imm);
    insn_t i;
    i = '{op, rd, rs0, rs1, imm};
    @(negedge clk);
    insn_valid = 1'b1;
    insn       = i;
    model(i);
    issued++;
  endtask

  task automatic load(input logic [2:0] rd, input logic [31:0] v);
    issue(OP_LDI, rd, 3'd0, 3'd0, v[15:0]);
    issue(OP_LDH, rd, rd, 3'd0, v[31:16]);  // depends on the ldi right before it
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    @(negedge clk);
    insn_valid = 1'b0;
    while (exp_q.size() != 0)
      @(negedge clk);
    $display("%-12s %0d errors", test_name, errors - test_errors);
  endtask

  // compares every result against the oldest outstanding expectation
  always @(negedge clk) begin
    if (rst_n && result_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("result_valid was set in %s with no instruction outstanding", test_name);
      end else begin
        head = exp_q.pop_front();
        check({test_name, " value"}, head.value, result);
        check({test_name, " rd"}, {29'h0, head.rd}, {29'h0, result_rd});
        check({test_name, " flags"}, {27'h0, head.st}, {27'h0, status});
      end
    end
  end

  task automatic constant_loads();
    start_test("loads");
    load(3'd1, 32'h1234_5678);
    load(3'd2, 32'hffff_ffff);
    load(3'd3, 32'h8000_0001);
    end_test();
  endtask

  task automatic edge_flags();
    start_test("edges");
    load(3'd0, 32'h0);
    load(3'd3, 32'hffff_ffff);
    load(3'd4, 32'h7fff_ffff);
    load(3'd5, 32'h1);
    load(3'd7, 32'h0000_00aa);
    issue(OP_ADD, 3'd6, 3'd4, 3'd5, 16'h0);  // signed overflow
    issue(OP_ADD, 3'd6, 3'd3, 3'd5, 16'h0);  // carry out and zero
    issue(OP_SUB, 3'd6, 3'd0, 3'd5, 16'h0);  // borrow
    issue(OP_SUB, 3'd6, 3'd4, 3'd3, 16'h0);
    issue(OP_CMP, 3'd7, 3'd4, 3'd4, 16'h0);
    issue(OP_CMP, 3'd7, 3'd0, 3'd3, 16'h0);
    issue(OP_OR, 3'd6, 3'd7, 3'd0, 16'h0);  // r7 must still hold 0xaa
    end_test();
  endtask

  task automatic carry_chain();
    start_test("carry_chain");
    load(3'd0, 32'h1);
    load(3'd1, 32'hffff_ffff);
    load(3'd2, 32'h2);
    load(3'd3, 32'h1);
    issue(OP_ADD, 3'd4, 3'd1, 3'd3, 16'h0);
    issue(OP_ADC, 3'd5, 3'd0, 3'd2, 16'h0);
    issue(OP_SUB, 3'd4, 3'd3, 3'd1, 16'h0);
    issue(OP_SBB, 3'd5, 3'd2, 3'd0, 16'h0);
    issue(OP_ADD, 3'd4, 3'd3, 3'd3, 16'h0);  // no carry into the adc
    issue(OP_ADC, 3'd5, 3'd0, 3'd0, 16'h0);
    end_test();
  endtask

  task automatic logic_mul_div();
    start_test("logic_mul_div");
    load(3'd0, 32'h0);
    load(3'd1, 32'hffff_ffff);
    load(3'd2, 32'h0000_f0f0);
    load(3'd3, 32'h0001_0001);
    load(3'd4, 32'h7);
    issue(OP_MUL, 3'd5, 3'd3, 3'd3, 16'h0);  // sets cf and of
    issue(OP_AND, 3'd5, 3'd1, 3'd2, 16'h0);
    issue(OP_MUL, 3'd5, 3'd3, 3'd3, 16'h0);
    issue(OP_OR, 3'd5, 3'd1, 3'd2, 16'h0);
    issue(OP_MUL, 3'd5, 3'd3, 3'd3, 16'h0);
    issue(OP_XOR, 3'd5, 3'd1, 3'd1, 16'h0);
    issue(OP_MUL, 3'd5, 3'd3, 3'd3, 16'h0);  // upper half nonzero
    issue(OP_MUL, 3'd5, 3'd2, 3'd4, 16'h0);
    issue(OP_DIV, 3'd5, 3'd1, 3'd4, 16'h0);
    issue(OP_DIV, 3'd5, 3'd2, 3'd0, 16'h0);
    end_test();
  endtask

  task automatic bypass_paths();
    start_test("bypass");
    load(3'd1, rand32());
    issue(OP_ADD, 3'd2, 3'd1, 3'd1, 16'h0);
    issue(OP_SUB, 3'd3, 3'd2, 3'd1, 16'h0);
    issue(OP_XOR, 3'd6, 3'd0, 3'd0, 16'h0);
    issue(OP_ADD, 3'd4, 3'd2, 3'd3, 16'h0);  // r3 two back and r2 three back
    issue(OP_MUL, 3'd5, 3'd4, 3'd4, 16'h0);
    issue(OP_ADD, 3'd6, 3'd5, 3'd4, 16'h0);
    end_test();
  endtask

  task automatic random_stream();
    logic [31:0] r;
    start_test("random");
    for (int n = 0; n < 200; n++) begin
      r = rand32();
      issue(opcode_t'(4'(r[7:0] % 12)), r[10:8], r[13:11], r[16:14], r[31:16]);
    end
    end_test();
  endtask

  initial begin
    cycles = 0;
    while (cycles <= 40 * issued + 200) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles with %0d results outstanding", cycles, exp_q.size());
    $display("Regression failed");
    $finish;
  end

  initial begin
    rst_n       = 1'b0;
    insn_valid  = 1'b0;
    insn        = '0;
    rng         = 32'h2da2fef7;
    checks      = 0;
    errors      = 0;
    issued      = 0;
    model_flags = '0;
    for (int r = 0; r < `EXEC_NREGS; r++)
      model_regs[r] = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    constant_loads();
    edge_flags();
    carry_chain();
    logic_mul_div();
    bypass_paths();
    random_stream();
    $display("%0d instructions, %0d checks, %0d errors", issued, checks, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+logic
logic/exec_pkg.sv
logic/insn_decode.sv
logic/operand_fetch.sv
logic/alu.sv
logic/execute_stage.sv
logic/exec_core.sv
testbench/exec_core_chk.sv
testbench/exec_core_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module exec_core_tb -f sim.f
	@out=$$(./obj_dir/Vexec_core_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir
